//--- src/periph_bus_pkg.sv
// peripheral bus definitions
package periph_bus_pkg;

    // bus widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;

    // number of timer instances behind the port
    localparam int NUM_TIMERS = 2;

    // address map
    // timer 0 at 0x00, timer 1 at 0x10
    localparam int TIMER_SEL_BIT = 4;
    // bits above the timer select up to here must be zero
    localparam int REGION_TOP_BIT = 31;

    // access kind decoded for the current cycle
    // only non-none in a cycle where the request is accepted
    typedef enum logic [1:0] {
        ACC_NONE  = 2'b00,
        ACC_READ  = 2'b01,
        ACC_WRITE = 2'b10
    } access_e;

endpackage

//--- src/timer_pkg.sv
// timer register map
package timer_pkg;

    // register offsets within one timer
    localparam logic [3:0] REG_CTRL  = 4'h0;
    // read only, writes ignored
    localparam logic [3:0] REG_COUNT = 4'h4;
    localparam logic [3:0] REG_VALUE = 4'h8;

    // control register bits
    // counter running
    localparam int CTRL_EN_BIT   = 0;
    // expiry raises pending
    localparam int CTRL_IE_BIT   = 1;
    // write 1 to clear
    localparam int CTRL_PEND_BIT = 2;

endpackage

//--- src/periph_decode.sv
// peripheral access decoder
`timescale 1ns/1ps

module periph_decode
    import periph_bus_pkg::*;
(
    input  logic              req_valid_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [3:0]        sel_i,
    input  logic              req_ready_i,
    output access_e           acc_o,
    output logic              timer_sel_o,
    output logic              mapped_o,
    output logic [3:0]        offset_o,
    output access_e           timer_acc_o [NUM_TIMERS],
    output logic [3:0]        strb_o
);

    logic    accept;
    logic    mapped;
    access_e acc;

    // handshake, request taken this edge
    assign accept = req_valid_i & req_ready_i;

    // access kind only when accepted
    assign acc = accept ? (we_i ? ACC_WRITE : ACC_READ) : ACC_NONE;

    // everything above the timer select must be zero
    assign mapped = ~|addr_i[REGION_TOP_BIT:TIMER_SEL_BIT+1];

    assign acc_o       = acc;
    assign mapped_o    = mapped;
    assign timer_sel_o = addr_i[TIMER_SEL_BIT];
    assign offset_o    = addr_i[3:0];

    // byte lanes only matter on a write
    assign strb_o = (acc == ACC_WRITE) ? sel_i : 4'b0000;

    // steer the access to the addressed timer
    // unmapped accesses reach no timer at all
    always_comb begin
        for (int i = 0; i < NUM_TIMERS; i++) begin
            timer_acc_o[i] = ACC_NONE;
            if (mapped && (int'(addr_i[TIMER_SEL_BIT]) == i)) begin
                timer_acc_o[i] = acc;
            end
        end
    end

endmodule

//--- src/timer.sv
// one-shot 32-bit timer
`timescale 1ns/1ps

module timer
    import periph_bus_pkg::*;
    import timer_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  access_e           acc_i,
    input  logic [3:0]        offset_i,
    input  logic [3:0]        strb_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic [DATA_W-1:0] rdata_o,
    output logic              irq_o
);

    // control, only the low byte is implemented
    logic [7:0]        ctrl_q;
    // running count, read only
    logic [DATA_W-1:0] count_q;
    // compare value
    logic [DATA_W-1:0] value_q;

    logic wr;
    logic ctrl_wr;
    logic value_wr;
    logic en;
    logic ie;
    logic pend;
    logic expired;
    logic pend_clr;
    logic pend_set;

    assign wr       = (acc_i == ACC_WRITE);
    // ctrl lives in lane 0 only
    assign ctrl_wr  = wr && (offset_i == REG_CTRL) && strb_i[0];
    assign value_wr = wr && (offset_i == REG_VALUE);

    assign en   = ctrl_q[CTRL_EN_BIT];
    assign ie   = ctrl_q[CTRL_IE_BIT];
    assign pend = ctrl_q[CTRL_PEND_BIT];

    // reached the compare value while running
    assign expired = en && (count_q >= value_q);

    // pending is write 1 to clear
    assign pend_clr = ctrl_wr && wdata_i[CTRL_PEND_BIT];
    // a clearing write beats a same-cycle expiry
    assign pend_set = expired && ie && !pend_clr;

    // counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else begin
            if (!en) begin
                // idle timer sits at zero
                count_q <= '0;
            end else if (expired) begin
                count_q <= '0;
            end else begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    // control register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= '0;
        end else begin
            if (ctrl_wr) begin
                // software write wins over expiry
                ctrl_q[7:3]         <= wdata_i[7:3];
                ctrl_q[CTRL_IE_BIT] <= wdata_i[CTRL_IE_BIT];
                ctrl_q[CTRL_EN_BIT] <= wdata_i[CTRL_EN_BIT];
            end else if (expired) begin
                // one-shot, stop on expiry
                ctrl_q[CTRL_EN_BIT] <= 1'b0;
            end
            if (pend_set) begin
                ctrl_q[CTRL_PEND_BIT] <= 1'b1;
            end else if (pend_clr) begin
                ctrl_q[CTRL_PEND_BIT] <= 1'b0;
            end
        end
    end

    // compare value, per byte lane
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            value_q <= '0;
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (value_wr && strb_i[b]) begin
                    value_q[8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // pending drives the line straight out
    assign irq_o = pend;

    // read mux for the presented offset
    always_comb begin
        case (offset_i)
            REG_CTRL:  rdata_o = {{(DATA_W-8){1'b0}}, ctrl_q};
            REG_COUNT: rdata_o = count_q;
            REG_VALUE: rdata_o = value_q;
            // unknown offset reads zero
            default:   rdata_o = '0;
        endcase
    end

endmodule

//--- src/periph_response.sv
// one-entry response buffer
`timescale 1ns/1ps

module periph_response
    import periph_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  access_e           acc_i,
    input  logic              timer_sel_i,
    input  logic              mapped_i,
    input  logic [DATA_W-1:0] timer_rdata_i [NUM_TIMERS],
    input  logic              rsp_ready_i,
    output logic              req_ready_o,
    output logic              rsp_valid_o,
    output logic [DATA_W-1:0] rsp_data_o
);

    logic              valid_q;
    // held response carries read data
    logic              rd_hit_q;
    logic [DATA_W-1:0] data_q;
    logic              accept;

    // decode only issues an access when the request was accepted
    assign accept = (acc_i != ACC_NONE);

    // free when empty, or when the held response leaves this cycle
    assign req_ready_o = !valid_q || rsp_ready_i;

    // valid flag and read-hit flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= 1'b0;
            rd_hit_q <= 1'b0;
        end else begin
            if (accept) begin
                valid_q  <= 1'b1;
                // writes and unmapped reads answer zero
                rd_hit_q <= (acc_i == ACC_READ) && mapped_i;
            end else if (rsp_ready_i) begin
                // consumed, nothing new behind it
                valid_q <= 1'b0;
            end
        end
    end

    // captured word, held until consumed
    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= timer_rdata_i[timer_sel_i];
        end
    end

    assign rsp_valid_o = valid_q;
    // masked unless the held access was a mapped read
    assign rsp_data_o  = rd_hit_q ? data_q : '0;

endmodule

//--- src/timer_periph_top.sv
// dual timer peripheral
`timescale 1ns/1ps

module timer_periph_top
    import periph_bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // request channel
    input  logic                  req_valid_i,
    input  logic                  we_i,
    input  logic [ADDR_W-1:0]     addr_i,
    input  logic [DATA_W-1:0]     data_i,
    input  logic [3:0]            sel_i,
    output logic                  req_ready_o,
    // response channel
    output logic                  rsp_valid_o,
    output logic [DATA_W-1:0]     data_o,
    input  logic                  rsp_ready_i,
    // one line per timer
    output logic [NUM_TIMERS-1:0] irq_o
);

    access_e           acc;
    access_e           timer_acc [NUM_TIMERS];
    logic              timer_sel;
    logic              mapped;
    logic [3:0]        offset;
    logic [3:0]        strb;
    logic [DATA_W-1:0] timer_rdata [NUM_TIMERS];
    logic              req_ready;

    // address and access decode
    periph_decode u_decode (
        .req_valid_i (req_valid_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .sel_i       (sel_i),
        .req_ready_i (req_ready),
        .acc_o       (acc),
        .timer_sel_o (timer_sel),
        .mapped_o    (mapped),
        .offset_o    (offset),
        .timer_acc_o (timer_acc),
        .strb_o      (strb)
    );

    // timer at 0x00
    timer u_timer0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .acc_i    (timer_acc[0]),
        .offset_i (offset),
        .strb_i   (strb),
        .wdata_i  (data_i),
        .rdata_o  (timer_rdata[0]),
        .irq_o    (irq_o[0])
    );

    // timer at 0x10
    timer u_timer1 (
        .clk      (clk),
        .rst_n    (rst_n),
        .acc_i    (timer_acc[1]),
        .offset_i (offset),
        .strb_i   (strb),
        .wdata_i  (data_i),
        .rdata_o  (timer_rdata[1]),
        .irq_o    (irq_o[1])
    );

    // response stage, also owns request ready
    periph_response u_response (
        .clk           (clk),
        .rst_n         (rst_n),
        .acc_i         (acc),
        .timer_sel_i   (timer_sel),
        .mapped_i      (mapped),
        .timer_rdata_i (timer_rdata),
        .rsp_ready_i   (rsp_ready_i),
        .req_ready_o   (req_ready),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_data_o    (data_o)
    );

    assign req_ready_o = req_ready;

endmodule

//--- verification/tb_timer_periph.sv
// dual timer peripheral testbench
`timescale 1ns/1ps

module tb_timer_periph
    import periph_bus_pkg::*;
    import timer_pkg::*;
();

    localparam int CLK_HALF   = 4;
    localparam int WAIT_LIMIT = 50;
    localparam int POLL_LIMIT = 100;
    localparam int MAX_STEPS  = 64;
    // timer base addresses
    localparam logic [ADDR_W-1:0] T0 = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] T1 = 32'h1 << TIMER_SEL_BIT;

    // poll repeats CTRL reads until the enable bit drops
    typedef enum logic [2:0] {OP_WR, OP_RD, OP_POLL, OP_RVAL, OP_STALL} op_e;

    typedef struct packed {
        op_e               op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [3:0]        strb;
        logic [DATA_W-1:0] exp;
        logic [1:0]        irq;
    } step_t;

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid_i;
    logic                  we_i;
    logic [ADDR_W-1:0]     addr_i;
    logic [DATA_W-1:0]     data_i;
    logic [3:0]            sel_i;
    logic                  rsp_ready_i;
    logic                  req_ready_o;
    logic                  rsp_valid_o;
    logic [DATA_W-1:0]     data_o;
    logic [NUM_TIMERS-1:0] irq_o;

    step_t             steps [MAX_STEPS];
    int                n_steps;
    int                err_cnt;
    int                timeout_cnt;
    logic [31:0]       lfsr;
    // expected VALUE registers
    logic [DATA_W-1:0] value_m [NUM_TIMERS];

    timer_periph_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (req_valid_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .data_i      (data_i),
        .sel_i       (sel_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .data_o      (data_o),
        .rsp_ready_i (rsp_ready_i),
        .irq_o       (irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // only strobed byte lanes take the new data
    function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] wd,
                                                input logic [3:0] strb);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                r[8*b +: 8] = wd[8*b +: 8];
            end
        end
        return r;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
            err_cnt++;
        end
    endtask

    task automatic end_run();
        $display("errors: %0d mismatches, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic note_timeout(input string what);
        $display("%s at %0t", what, $time);
        timeout_cnt++;
    endtask

    // holds until accepted, then waits for the one response
    task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] wd,
                              input logic [3:0] strb, output logic [31:0] rd);
        int cnt;
        @(negedge clk);
        req_valid_i = 1'b1;
        we_i        = we;
        addr_i      = addr;
        data_i      = wd;
        sel_i       = strb;
        cnt         = 0;
        // ready seen mid-cycle means accept at the next rising edge
        while (!req_ready_o && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (cnt >= WAIT_LIMIT) begin
            note_timeout("request was never accepted");
        end
        @(negedge clk);
        req_valid_i = 1'b0;
        we_i        = 1'b0;
        cnt         = 0;
        while (!rsp_valid_o && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (cnt >= WAIT_LIMIT) begin
            note_timeout("no response arrived");
        end
        // rsp_ready_i is high, consumed at the next edge
        rd = data_o;
        @(negedge clk);
        if (rsp_valid_o) begin
            $display("a second response showed up for one request at %0t", $time);
            err_cnt++;
        end
    endtask

    // read with the response held back, a second read queued behind it
    task automatic stalled_read(input logic [31:0] addr, input logic [31:0] exp);
        int          stall;
        int          cnt;
        logic [31:0] held;
        stall = 1 + int'(lfsr_bits(3));
        @(negedge clk);
        rsp_ready_i = 1'b0;
        req_valid_i = 1'b1;
        we_i        = 1'b0;
        addr_i      = addr;
        sel_i       = 4'hf;
        cnt         = 0;
        while (!req_ready_o && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (cnt >= WAIT_LIMIT) begin
            note_timeout("stalled read was never accepted");
        end
        @(negedge clk);
        held = data_o;
        check_word("rsp_valid_o", 32'(rsp_valid_o), 32'h1);
        check_word("data_o", held, exp);
        for (int i = 0; i < stall; i++) begin
            @(negedge clk);
            check_word("rsp_valid_o", 32'(rsp_valid_o), 32'h1);
            check_word("data_o", data_o, held);
            check_word("req_ready_o", 32'(req_ready_o), 32'h0);
        end
        rsp_ready_i = 1'b1;
        // held response leaves and the queued read enters on the same edge
        @(negedge clk);
        req_valid_i = 1'b0;
        check_word("rsp_valid_o", 32'(rsp_valid_o), 32'h1);
        check_word("data_o", data_o, exp);
        @(negedge clk);
        check_word("rsp_valid_o", 32'(rsp_valid_o), 32'h0);
    endtask

    task automatic add_step(input op_e op, input logic [31:0] addr, input logic [31:0] wd,
                            input logic [3:0] strb, input logic [31:0] exp, input logic [1:0] irq);
        steps[n_steps] = '{op, addr, wd, strb, exp, irq};
        n_steps++;
    endtask

    task automatic build_table();
        n_steps = 0;
        // reset values
        add_step(OP_RD, T0 + REG_CTRL, 0, 4'hf, 0, 2'b00);
        add_step(OP_RD, T0 + REG_COUNT, 0, 4'hf, 0, 2'b00);
        add_step(OP_RD, T0 + REG_VALUE, 0, 4'hf, 0, 2'b00);
        add_step(OP_RD, T1 + REG_CTRL, 0, 4'hf, 0, 2'b00);
        add_step(OP_RD, T1 + REG_COUNT, 0, 4'hf, 0, 2'b00);
        add_step(OP_RD, T1 + REG_VALUE, 0, 4'hf, 0, 2'b00);
        // random lanes into VALUE
        add_step(OP_RVAL, T0 + REG_VALUE, 0, 0, 0, 2'b00);
        add_step(OP_RVAL, T0 + REG_VALUE, 0, 0, 0, 2'b00);
        add_step(OP_RVAL, T1 + REG_VALUE, 0, 0, 0, 2'b00);
        // ctrl only listens to lane 0
        add_step(OP_WR, T0 + REG_CTRL, 32'hffff_fff8, 4'b1110, 0, 2'b00);
        add_step(OP_RD, T0 + REG_CTRL, 0, 4'hf, 0, 2'b00);
        add_step(OP_WR, T1 + REG_CTRL, 32'h0000_00f8, 4'b0001, 0, 2'b00);
        add_step(OP_RD, T1 + REG_CTRL, 0, 4'hf, 32'h0000_00f8, 2'b00);
        add_step(OP_WR, T1 + REG_CTRL, 0, 4'b0001, 0, 2'b00);
        // count is read only, written while running far below the compare value
        add_step(OP_WR, T0 + REG_VALUE, 32'hffff_0000, 4'hf, 0, 2'b00);
        add_step(OP_WR, T0 + REG_CTRL, 32'h1, 4'b0001, 0, 2'b00);
        add_step(OP_WR, T0 + REG_COUNT, 32'hffff_ffff, 4'hf, 0, 2'b00);
        // a written count would have expired the timer
        add_step(OP_RD, T0 + REG_CTRL, 0, 4'hf, 32'h1, 2'b00);
        add_step(OP_WR, T0 + REG_CTRL, 0, 4'b0001, 0, 2'b00);
        add_step(OP_RD, T0 + REG_COUNT, 0, 4'hf, 0, 2'b00);
        add_step(OP_WR, T0 + REG_VALUE, 32'h5, 4'hf, 0, 2'b00);
        add_step(OP_WR, T1 + REG_VALUE, 32'h3, 4'hf, 0, 2'b00);
        // timer 0 one-shot with interrupt
        add_step(OP_WR, T0 + REG_CTRL, 32'h3, 4'b0001, 0, 2'b00);
        add_step(OP_POLL, T0 + REG_CTRL, 0, 4'hf, 32'h6, 2'b01);
        add_step(OP_RD, T0 + REG_COUNT, 0, 4'hf, 0, 2'b01);
        add_step(OP_RD, T1 + REG_CTRL, 0, 4'hf, 0, 2'b01);
        // pending survives a zero in bit 2, then clears
        add_step(OP_WR, T0 + REG_CTRL, 32'h2, 4'b0001, 0, 2'b01);
        add_step(OP_RD, T0 + REG_CTRL, 0, 4'hf, 32'h6, 2'b01);
        add_step(OP_WR, T0 + REG_CTRL, 32'h4, 4'b0001, 0, 2'b00);
        add_step(OP_RD, T0 + REG_CTRL, 0, 4'hf, 0, 2'b00);
        // timer 1 expiry, first without interrupt enable
        add_step(OP_WR, T1 + REG_CTRL, 32'h1, 4'b0001, 0, 2'b00);
        add_step(OP_POLL, T1 + REG_CTRL, 0, 4'hf, 0, 2'b00);
        add_step(OP_WR, T1 + REG_CTRL, 32'h3, 4'b0001, 0, 2'b00);
        add_step(OP_POLL, T1 + REG_CTRL, 0, 4'hf, 32'h6, 2'b10);
        add_step(OP_WR, T1 + REG_CTRL, 32'h4, 4'b0001, 0, 2'b00);
        // back-pressure
        add_step(OP_STALL, T0 + REG_VALUE, 0, 4'hf, 32'h5, 2'b00);
        add_step(OP_STALL, T1 + REG_VALUE, 0, 4'hf, 32'h3, 2'b00);
        // unknown offsets and upper address bits
        add_step(OP_RD, T0 + 4'hc, 0, 4'hf, 0, 2'b00);
        add_step(OP_RD, T1 + 4'hc, 0, 4'hf, 0, 2'b00);
        add_step(OP_RD, 32'h0000_0028, 0, 4'hf, 0, 2'b00);
        add_step(OP_RD, 32'h8000_0008, 0, 4'hf, 0, 2'b00);
        add_step(OP_WR, T0 + 4'hc, 32'hffff_ffff, 4'hf, 0, 2'b00);
        add_step(OP_WR, T1 + 4'hc, 32'hffff_ffff, 4'hf, 0, 2'b00);
        add_step(OP_WR, 32'h0000_0028, 32'hffff_ffff, 4'hf, 0, 2'b00);
        add_step(OP_WR, 32'h4000_0010, 32'h3, 4'hf, 0, 2'b00);
        // nothing moved
        add_step(OP_RD, T0 + REG_CTRL, 0, 4'hf, 0, 2'b00);
        add_step(OP_RD, T0 + REG_COUNT, 0, 4'hf, 0, 2'b00);
        add_step(OP_RD, T0 + REG_VALUE, 0, 4'hf, 32'h5, 2'b00);
        add_step(OP_RD, T1 + REG_CTRL, 0, 4'hf, 0, 2'b00);
        add_step(OP_RD, T1 + REG_COUNT, 0, 4'hf, 0, 2'b00);
        add_step(OP_RD, T1 + REG_VALUE, 0, 4'hf, 32'h3, 2'b00);
    endtask

    initial begin
        step_t       st;
        logic [31:0] rd;
        logic [31:0] wd;
        logic [3:0]  strb;
        int          polls;
        rst_n       = 1'b0;
        req_valid_i = 1'b0;
        we_i        = 1'b0;
        addr_i      = '0;
        data_i      = '0;
        sel_i       = '0;
        rsp_ready_i = 1'b1;
        err_cnt     = 0;
        timeout_cnt = 0;
        lfsr        = 32'h6804_d9aa;
        value_m[0]  = '0;
        value_m[1]  = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_word("req_ready_o", 32'(req_ready_o), 32'h1);
        check_word("irq_o", 32'(irq_o), 32'h0);
        build_table();
        for (int s = 0; s < n_steps; s++) begin
            st = steps[s];
            case (st.op)
                OP_WR: begin
                    // write responses carry zero
                    bus_access(1'b1, st.addr, st.wdata, st.strb, rd);
                    check_word("data_o", rd, 32'h0);
                end
                OP_RD: begin
                    bus_access(1'b0, st.addr, '0, st.strb, rd);
                    check_word("data_o", rd, st.exp);
                end
                OP_POLL: begin
                    polls = 0;
                    rd    = 32'h1;
                    while (rd[CTRL_EN_BIT] && polls < POLL_LIMIT) begin
                        bus_access(1'b0, st.addr, '0, 4'hf, rd);
                        polls++;
                    end
                    if (rd[CTRL_EN_BIT]) begin
                        note_timeout("timer kept running past the poll limit");
                    end else begin
                        check_word("data_o", rd, st.exp);
                    end
                end
                OP_RVAL: begin
                    wd   = lfsr_bits(32);
                    strb = lfsr_bits(4);
                    value_m[st.addr[TIMER_SEL_BIT]] =
                        merge_lanes(value_m[st.addr[TIMER_SEL_BIT]], wd, strb);
                    bus_access(1'b1, st.addr, wd, strb, rd);
                    bus_access(1'b0, st.addr, '0, 4'hf, rd);
                    check_word("data_o", rd, value_m[st.addr[TIMER_SEL_BIT]]);
                end
                default: begin
                    stalled_read(st.addr, st.exp);
                end
            endcase
            check_word("irq_o", 32'(irq_o), 32'(st.irq));
        end
        end_run();
    end

endmodule

//--- tb.f
src/periph_bus_pkg.sv
src/timer_pkg.sv
src/periph_decode.sv
src/timer.sv
src/periph_response.sv
src/timer_periph_top.sv
verification/tb_timer_periph.sv

//--- Makefile
# tool, flags, top module and file list
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_timer_periph
FLIST     = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = TEST PASSED

SRCS = $(shell cat $(FLIST))
SIM  = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the log decides pass or fail
run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
